// File: files.f
+incdir+src
src/motion_pkg.sv
src/host_reg_decode.sv
src/gpio_out_group.sv
src/gpio_in_group.sv
src/step_pulse_gen.sv
src/motion_ctrl_top.sv
test/tb_motion_ctrl.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/10ps
TOP      = tb_motion_ctrl
FILELIST = files.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Done: no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: test/tb_motion_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "motion_settings.svh"

module tb_motion_ctrl import motion_pkg::*; ;

    logic                           sys_clk;
    logic                           rst_n;
    logic                           bus_wr;
    logic                           bus_rd;
    addr_t                          bus_addr;
    data_t                          bus_wdata;
    data_t                          bus_rdata;
    logic                           rd_valid;
    gpio_t                          gpio_in;
    gpio_t                          gpio_out;
    logic [`MOTION_MOTOR_COUNT-1:0] motor_estop;
    logic [`MOTION_MOTOR_COUNT-1:0] motor_enable;
    logic [`MOTION_MOTOR_COUNT-1:0] motor_dir;
    logic [`MOTION_MOTOR_COUNT-1:0] motor_pulse;
    logic [`MOTION_MOTOR_COUNT-1:0] motor_irq;
    logic [31:0]                    lfsr_state;

    motion_ctrl_top u_dut (
        .sys_clk      (sys_clk),
        .rst_n        (rst_n),
        .bus_wr       (bus_wr),
        .bus_rd       (bus_rd),
        .bus_addr     (bus_addr),
        .bus_wdata    (bus_wdata),
        .bus_rdata    (bus_rdata),
        .rd_valid     (rd_valid),
        .gpio_in      (gpio_in),
        .gpio_out     (gpio_out),
        .motor_estop  (motor_estop),
        .motor_enable (motor_enable),
        .motor_dir    (motor_dir),
        .motor_pulse  (motor_pulse),
        .motor_irq    (motor_irq)
    );

    always #50 sys_clk = ~sys_clk;   // 100 ns period

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("Done: errors found");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_eq(input string what, input data_t got, input data_t exp);
        assert (got == exp) else
            stop_run($sformatf("** Error at %0t: %s is %h, expected %h", $time, what, got, exp));
    endtask

    // galois form with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end else begin
            return s >> 1;
        end
    endfunction

    function automatic data_t rand_bits(input int n);
        data_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i]       = lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    function automatic addr_t motor_addr(input int m, input int idx);
        return addr_t'(((`MOTION_BLK_MOTOR_BASE + m) << 8) + idx);
    endfunction

    task automatic bus_write(input addr_t addr, input data_t data);
        @(posedge sys_clk);
        bus_wr    <= 1'b1;
        bus_addr  <= addr;
        bus_wdata <= data;
        @(posedge sys_clk);
        bus_wr <= 1'b0;
        @(negedge sys_clk);   // register already updated here
    endtask

    task automatic bus_read(input addr_t addr, output data_t data);
        int waited;
        waited = 0;
        @(posedge sys_clk);
        bus_rd   <= 1'b1;
        bus_addr <= addr;
        @(posedge sys_clk);
        bus_rd <= 1'b0;
        @(negedge sys_clk);
        while (!rd_valid) begin
            if (waited >= 10) begin
                stop_run("timeout: rd_valid did not arrive after a bus read");
            end else begin
                waited++;
                @(negedge sys_clk);
            end
        end
        data = bus_rdata;
    endtask

    task automatic read_check(input string what, input addr_t addr, input data_t exp);
        data_t got;
        bus_read(addr, got);
        check_eq(what, got, exp);
    endtask

    // full move on one channel with the pulse shape measured at each falling edge
    task automatic run_move(input int m, input data_t hp, input data_t cnt, input logic dir);
        int   rises;
        int   high_len;
        int   low_len;
        int   waited;
        int   limit;
        logic prev;
        rises    = 0;
        high_len = 0;
        low_len  = 0;
        waited   = 0;
        prev     = 1'b0;
        limit    = int'(2 * hp * cnt) + 20;
        bus_write(motor_addr(m, 0), data_t'({dir, 1'b1}));
        check_eq("motor_enable", data_t'(motor_enable[m]), 1);
        check_eq("motor_dir", data_t'(motor_dir[m]), data_t'(dir));
        bus_write(motor_addr(m, 1), hp);
        bus_write(motor_addr(m, 2), cnt);   // starts the move
        while (!motor_irq[m]) begin
            if (motor_pulse[m]) begin
                if (!prev) rises++;
                high_len++;
            end else if (prev) begin
                check_eq("high phase length", data_t'(high_len), hp);
                high_len = 0;
                low_len  = 1;
            end else begin
                low_len++;
            end
            prev = motor_pulse[m];
            if (waited >= limit) begin
                stop_run($sformatf("timeout: motor %0d move never finished", m));
            end else begin
                waited++;
                @(negedge sys_clk);
            end
        end
        check_eq("last low phase length", data_t'(low_len), hp);
        check_eq("rising pulse edges", data_t'(rises), cnt);
        read_check("status after move", motor_addr(m, 3), 32'h2);
        bus_write(motor_addr(m, 3), '0);
        check_eq("motor_irq after clear", data_t'(motor_irq[m]), 0);
    endtask

    for (genvar m = 0; m < `MOTION_MOTOR_COUNT; m++) begin : g_motor_chk
        a_pulse_en: assert property (@(posedge sys_clk) disable iff (!rst_n)
            motor_pulse[m] |-> motor_enable[m])
            else stop_run($sformatf("** Error at %0t: motor %0d pulse high while disabled",
                                    $time, m));

        // estop forces the pulse low on the next edge
        a_estop_stops: assert property (@(posedge sys_clk) disable iff (!rst_n)
            $past(motor_estop[m]) |-> !motor_pulse[m])
            else stop_run($sformatf("** Error at %0t: motor %0d pulsed during estop", $time, m));
    end

    a_rd_valid: assert property (@(posedge sys_clk) disable iff (!rst_n)
        rd_valid |-> $past(bus_rd))
        else stop_run($sformatf("** Error at %0t: rd_valid without a read", $time));

    initial begin
        gpio_t gpio_model;
        gpio_t mask;
        gpio_t pins_a;
        gpio_t pins_b;
        data_t hp;
        data_t cnt;
        sys_clk     = 1'b0;
        rst_n       = 1'b0;
        bus_wr      = 1'b0;
        bus_rd      = 1'b0;
        bus_addr    = '0;
        bus_wdata   = '0;
        gpio_in     = '0;
        motor_estop = '0;
        lfsr_state  = 32'd73;

        repeat (8) @(posedge sys_clk);
        rst_n <= 1'b1;
        @(negedge sys_clk);
        check_eq("gpio_out after reset", data_t'(gpio_out), 0);
        check_eq("motor_pulse after reset", data_t'(motor_pulse), 0);
        check_eq("motor_irq after reset", data_t'(motor_irq), 0);
        check_eq("rd_valid after reset", data_t'(rd_valid), 0);
        read_check("gpio in mode after reset", 16'h0100, '1);

        // gpio out direct then set then clear
        gpio_model = gpio_t'(rand_bits(32));
        bus_write(16'h0000, data_t'(gpio_model));
        check_eq("gpio_out direct", data_t'(gpio_out), data_t'(gpio_model));
        read_check("gpio out state", 16'h0000, data_t'(gpio_model));
        mask       = gpio_t'(rand_bits(32));
        gpio_model = gpio_model | mask;
        bus_write(16'h0001, data_t'(mask));
        check_eq("gpio_out set", data_t'(gpio_out), data_t'(gpio_model));
        read_check("gpio out set readback", 16'h0001, data_t'(gpio_model));
        mask       = gpio_t'(rand_bits(32));
        gpio_model = gpio_model & ~mask;
        bus_write(16'h0002, data_t'(mask));
        check_eq("gpio_out clear", data_t'(gpio_out), data_t'(gpio_model));
        read_check("gpio out clear readback", 16'h0002, data_t'(gpio_model));

        // gpio in sampling then per-bit hold
        pins_a = gpio_t'(rand_bits(32));
        @(posedge sys_clk);
        gpio_in <= pins_a;
        repeat (4) @(posedge sys_clk);
        read_check("gpio in sampled", 16'h0101, data_t'(pins_a));
        mask = gpio_t'(rand_bits(32));
        bus_write(16'h0100, data_t'(mask));
        read_check("gpio in mode", 16'h0100, data_t'(mask));
        pins_b = gpio_t'(rand_bits(32));
        @(posedge sys_clk);
        gpio_in <= pins_b;
        repeat (4) @(posedge sys_clk);
        read_check("gpio in held", 16'h0101, data_t'((pins_a & ~mask) | (pins_b & mask)));

        // plain move on motor 0
        hp  = rand_bits(2) + 1;
        cnt = rand_bits(3) + 1;
        run_move(0, hp, cnt, 1'b1);

        // a count write with enable low starts nothing
        bus_write(motor_addr(1, 2), 32'd3);
        read_check("motor 1 status while disabled", motor_addr(1, 3), 32'h0);
        check_eq("motor 1 pulse while disabled", data_t'(motor_pulse[1]), 0);

        // motor 1 aborted by estop while motor 0 runs a move of its own
        bus_write(motor_addr(1, 0), 32'h1);
        bus_write(motor_addr(1, 1), 32'd4);
        bus_write(motor_addr(1, 2), 32'd20);
        hp  = rand_bits(2) + 1;
        cnt = rand_bits(3) + 1;
        fork
            run_move(0, hp, cnt, 1'b0);
            begin
                repeat (5) @(posedge sys_clk);
                motor_estop[1] <= 1'b1;
                repeat (6) @(posedge sys_clk);
                motor_estop[1] <= 1'b0;
            end
        join
        read_check("motor 1 status after estop", motor_addr(1, 3), 32'h4);
        check_eq("motor 1 irq after estop", data_t'(motor_irq[1]), 0);
        check_eq("motor 1 pulse after estop", data_t'(motor_pulse[1]), 0);
        bus_write(motor_addr(1, 3), '0);
        read_check("motor 1 status cleared", motor_addr(1, 3), 32'h0);

        // unmapped blocks
        read_check("unmapped read", 16'h2000, 32'h0);
        bus_write(16'h2000, rand_bits(32));
        bus_write(motor_addr(`MOTION_MOTOR_COUNT, 1), rand_bits(32));
        read_check("gpio out after stray write", 16'h0000, data_t'(gpio_model));
        read_check("gpio in mode after stray write", 16'h0100, data_t'(mask));
        read_check("motor 0 period after stray write", motor_addr(0, 1), hp);

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: src/motion_ctrl_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "motion_settings.svh"

module motion_ctrl_top import motion_pkg::*; (
    input  logic                           sys_clk,
    input  logic                           rst_n,
    input  logic                           bus_wr,
    input  logic                           bus_rd,
    input  addr_t                          bus_addr,
    input  data_t                          bus_wdata,
    output data_t                          bus_rdata,
    output logic                           rd_valid,
    input  gpio_t                          gpio_in,
    output gpio_t                          gpio_out,
    input  logic [`MOTION_MOTOR_COUNT-1:0] motor_estop,
    output logic [`MOTION_MOTOR_COUNT-1:0] motor_enable,
    output logic [`MOTION_MOTOR_COUNT-1:0] motor_dir,
    output logic [`MOTION_MOTOR_COUNT-1:0] motor_pulse,
    output logic [`MOTION_MOTOR_COUNT-1:0] motor_irq
);

    logic                           gpio_out_wr;
    logic                           gpio_in_wr;
    logic [`MOTION_MOTOR_COUNT-1:0] motor_wr;
    reg_idx_t                       reg_idx;
    data_t                          wdata;
    data_t                          gpio_out_rdata;
    data_t                          gpio_in_rdata;
    data_t                          motor_rdata [`MOTION_MOTOR_COUNT];

    host_reg_decode u_decode (
        .sys_clk        (sys_clk),
        .rst_n          (rst_n),
        .bus_wr         (bus_wr),
        .bus_rd         (bus_rd),
        .bus_addr       (bus_addr),
        .bus_wdata      (bus_wdata),
        .gpio_out_rdata (gpio_out_rdata),
        .gpio_in_rdata  (gpio_in_rdata),
        .motor_rdata    (motor_rdata),
        .gpio_out_wr    (gpio_out_wr),
        .gpio_in_wr     (gpio_in_wr),
        .motor_wr       (motor_wr),
        .reg_idx        (reg_idx),
        .wdata          (wdata),
        .bus_rdata      (bus_rdata),
        .rd_valid       (rd_valid)
    );

    gpio_out_group u_gpio_out (
        .sys_clk  (sys_clk),
        .rst_n    (rst_n),
        .wr       (gpio_out_wr),
        .reg_idx  (reg_idx),
        .wdata    (wdata),
        .rdata    (gpio_out_rdata),
        .gpio_out (gpio_out)
    );

    gpio_in_group u_gpio_in (
        .sys_clk (sys_clk),
        .rst_n   (rst_n),
        .wr      (gpio_in_wr),
        .reg_idx (reg_idx),
        .wdata   (wdata),
        .gpio_in (gpio_in),
        .rdata   (gpio_in_rdata)
    );

    // one channel and one irq per motor
    for (genvar m = 0; m < `MOTION_MOTOR_COUNT; m++) begin : g_motor
        step_pulse_gen u_motor (
            .sys_clk      (sys_clk),
            .rst_n        (rst_n),
            .wr           (motor_wr[m]),
            .reg_idx      (reg_idx),
            .wdata        (wdata),
            .motor_estop  (motor_estop[m]),
            .rdata        (motor_rdata[m]),
            .motor_enable (motor_enable[m]),
            .motor_dir    (motor_dir[m]),
            .motor_pulse  (motor_pulse[m]),
            .motor_irq    (motor_irq[m])
        );
    end

endmodule

`default_nettype wire

// File: src/step_pulse_gen.sv
`timescale 1ns/10ps
`default_nettype none

module step_pulse_gen import motion_pkg::*; (
    input  logic     sys_clk,
    input  logic     rst_n,
    input  logic     wr,
    input  reg_idx_t reg_idx,
    input  data_t    wdata,
    input  logic     motor_estop,
    output data_t    rdata,
    output logic     motor_enable,
    output logic     motor_dir,
    output logic     motor_pulse,
    output logic     motor_irq
);

    logic         ctrl_en;
    logic         ctrl_dir;
    period_t      half_period;
    step_cnt_t    step_count;    // programmed count, not the remaining one
    logic         done;
    logic         estop_latched;
    motor_state_e state;
    period_t      phase_cnt;     // cycles left in the current phase
    step_cnt_t    steps_left;
    period_t      hp_eff;
    logic         busy;
    logic         start;
    logic         stop;
    logic         disable_req;

    assign busy   = (state != MOTOR_IDLE);
    assign hp_eff = (half_period == '0) ? period_t'(1) : half_period;   // zero acts as 1

    assign start = wr && reg_idx == 4'd2 && ctrl_en && state == MOTOR_IDLE
                   && step_cnt_t'(wdata) != '0;
    assign stop        = motor_estop && busy;
    assign disable_req = wr && reg_idx == 4'd0 && !wdata[0] && busy;  // drop enable mid-move

    // config registers
    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            ctrl_en     <= 1'b0;
            ctrl_dir    <= 1'b0;
            half_period <= '0;
            step_count  <= '0;
        end else if (wr) begin
            case (reg_idx)
                4'd0: begin
                    ctrl_en  <= wdata[0];
                    ctrl_dir <= wdata[1];
                end
                4'd1:    half_period <= period_t'(wdata);
                4'd2:    step_count  <= step_cnt_t'(wdata);
                default: ;
            endcase
        end
    end

    // step fsm and status
    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            state         <= MOTOR_IDLE;
            motor_pulse   <= 1'b0;
            done          <= 1'b0;
            estop_latched <= 1'b0;
            phase_cnt     <= '0;
            steps_left    <= '0;
        end else begin
            if (wr && reg_idx == 4'd3) begin    // status write clears flags
                done          <= 1'b0;
                estop_latched <= 1'b0;
            end
            if (stop) begin
                state         <= MOTOR_IDLE;
                motor_pulse   <= 1'b0;
                estop_latched <= 1'b1;          // no done on abort
            end else if (disable_req) begin
                state       <= MOTOR_IDLE;
                motor_pulse <= 1'b0;
            end else begin
                case (state)
                    MOTOR_IDLE: begin
                        if (start) begin
                            state       <= MOTOR_HIGH;
                            motor_pulse <= 1'b1;
                            done        <= 1'b0;
                            phase_cnt   <= hp_eff - period_t'(1);
                            steps_left  <= step_cnt_t'(wdata);
                        end
                    end
                    MOTOR_HIGH: begin
                        if (phase_cnt == '0) begin
                            state       <= MOTOR_LOW;
                            motor_pulse <= 1'b0;
                            phase_cnt   <= hp_eff - period_t'(1);
                        end else begin
                            phase_cnt <= phase_cnt - period_t'(1);
                        end
                    end
                    MOTOR_LOW: begin
                        if (phase_cnt != '0) begin
                            phase_cnt <= phase_cnt - period_t'(1);
                        end else if (steps_left == step_cnt_t'(1)) begin
                            state <= MOTOR_IDLE;        // last low phase over
                            done  <= 1'b1;
                        end else begin
                            state       <= MOTOR_HIGH;
                            motor_pulse <= 1'b1;
                            phase_cnt   <= hp_eff - period_t'(1);
                            steps_left  <= steps_left - step_cnt_t'(1);
                        end
                    end
                    default: state <= MOTOR_IDLE;
                endcase
            end
        end
    end

    always_comb begin
        case (reg_idx)
            4'd0:    rdata = data_t'({ctrl_dir, ctrl_en});
            4'd1:    rdata = data_t'(half_period);
            4'd2:    rdata = data_t'(step_count);
            4'd3:    rdata = data_t'({estop_latched, done, busy});
            default: rdata = '0;
        endcase
    end

    assign motor_enable = ctrl_en;
    assign motor_dir    = ctrl_dir;
    assign motor_irq    = done;

    a_pulse_needs_en: assert property (@(posedge sys_clk) disable iff (!rst_n)
        motor_pulse |-> ctrl_en);

    a_busy_done_excl: assert property (@(posedge sys_clk) disable iff (!rst_n)
        !(busy && done));

endmodule

`default_nettype wire

// File: src/gpio_in_group.sv
`timescale 1ns/10ps
`default_nettype none

module gpio_in_group import motion_pkg::*; (
    input  logic     sys_clk,
    input  logic     rst_n,
    input  logic     wr,
    input  reg_idx_t reg_idx,
    input  data_t    wdata,
    input  gpio_t    gpio_in,
    output data_t    rdata
);

    gpio_t sync_q1;
    gpio_t sync_q2;
    gpio_t mode;        // 1 sample, 0 hold
    gpio_t sampled;

    // two-flop synchronizer on the raw pins
    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
        end else begin
            sync_q1 <= gpio_in;
            sync_q2 <= sync_q1;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            mode <= '1;                 // everything samples out of reset
        end else if (wr && reg_idx == 4'd0) begin
            mode <= gpio_t'(wdata);
        end
    end

    // per-bit sample or hold
    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            sampled <= '0;
        end else begin
            sampled <= (sampled & ~mode) | (sync_q2 & mode);
        end
    end

    always_comb begin
        case (reg_idx)
            4'd0:    rdata = data_t'(mode);
            4'd1:    rdata = data_t'(sampled);     // read-only
            default: rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: src/gpio_out_group.sv
`timescale 1ns/10ps
`default_nettype none

module gpio_out_group import motion_pkg::*; (
    input  logic     sys_clk,
    input  logic     rst_n,
    input  logic     wr,
    input  reg_idx_t reg_idx,
    input  data_t    wdata,
    output data_t    rdata,
    output gpio_t    gpio_out
);

    gpio_t state;     // pin state
    gpio_t wr_mask;

    assign wr_mask = gpio_t'(wdata);

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            state <= '0;
        end else if (wr) begin
            case (reg_idx)
                4'd0:    state <= wr_mask;              // direct
                4'd1:    state <= state | wr_mask;      // set mask
                4'd2:    state <= state & ~wr_mask;     // clear mask
                default: state <= state;
            endcase
        end
    end

    // all three registers show the current state
    always_comb begin
        if (reg_idx <= 4'd2) begin
            rdata = data_t'(state);
        end else begin
            rdata = '0;
        end
    end

    assign gpio_out = state;

endmodule

`default_nettype wire

// File: src/host_reg_decode.sv
`timescale 1ns/10ps
`default_nettype none

`include "motion_settings.svh"

module host_reg_decode import motion_pkg::*; (
    input  logic                           sys_clk,
    input  logic                           rst_n,
    input  logic                           bus_wr,
    input  logic                           bus_rd,
    input  addr_t                          bus_addr,
    input  data_t                          bus_wdata,
    input  data_t                          gpio_out_rdata,
    input  data_t                          gpio_in_rdata,
    input  data_t                          motor_rdata [`MOTION_MOTOR_COUNT],
    output logic                           gpio_out_wr,
    output logic                           gpio_in_wr,
    output logic [`MOTION_MOTOR_COUNT-1:0] motor_wr,
    output reg_idx_t                       reg_idx,
    output data_t                          wdata,
    output data_t                          bus_rdata,
    output logic                           rd_valid
);

    logic [7:0]                     blk;        // block code
    logic                           hit_gpio_out;
    logic                           hit_gpio_in;
    logic [`MOTION_MOTOR_COUNT-1:0] hit_motor;
    data_t                          rd_sel;

    assign blk          = bus_addr[15:8];
    assign hit_gpio_out = (blk == `MOTION_BLK_GPIO_OUT);
    assign hit_gpio_in  = (blk == `MOTION_BLK_GPIO_IN);

    always_comb begin
        for (int m = 0; m < `MOTION_MOTOR_COUNT; m++) begin
            hit_motor[m] = (blk == 8'(`MOTION_BLK_MOTOR_BASE + m));
        end
    end

    // unmatched writes raise no strobe
    assign gpio_out_wr = bus_wr && hit_gpio_out;
    assign gpio_in_wr  = bus_wr && hit_gpio_in;
    assign motor_wr    = {`MOTION_MOTOR_COUNT{bus_wr}} & hit_motor;
    assign reg_idx     = bus_addr[3:0];
    assign wdata       = bus_wdata;

    // read-back select reads zero when nothing matches
    always_comb begin
        rd_sel = '0;
        if (hit_gpio_out) begin
            rd_sel = gpio_out_rdata;
        end else if (hit_gpio_in) begin
            rd_sel = gpio_in_rdata;
        end
        for (int m = 0; m < `MOTION_MOTOR_COUNT; m++) begin
            if (hit_motor[m]) begin
                rd_sel = motor_rdata[m];
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (bus_rd) begin
            bus_rdata <= rd_sel;    // held until the next read
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= bus_rd;
        end
    end

    a_one_wr_strobe: assert property (@(posedge sys_clk) disable iff (!rst_n)
        $onehot0({gpio_out_wr, gpio_in_wr, motor_wr}));

    // host never reads and writes in the same cycle
    a_no_rd_wr_overlap: assert property (@(posedge sys_clk) disable iff (!rst_n)
        !(bus_wr && bus_rd));

endmodule

`default_nettype wire

// File: src/motion_pkg.sv
`default_nettype none

package motion_pkg;

    `include "motion_settings.svh"

    typedef logic [`MOTION_DATA_W-1:0]   data_t;
    typedef logic [`MOTION_ADDR_W-1:0]   addr_t;
    typedef logic [3:0]                  reg_idx_t;   // addr bits 3:0
    typedef logic [`MOTION_GPIO_W-1:0]   gpio_t;
    typedef logic [`MOTION_PERIOD_W-1:0] period_t;    // half-period in clocks
    typedef logic [`MOTION_STEP_W-1:0]   step_cnt_t;

    // step pulse phases
    typedef enum logic [1:0] {
        MOTOR_IDLE,
        MOTOR_HIGH,
        MOTOR_LOW
    } motor_state_e;

endpackage

`default_nettype wire

// File: src/motion_settings.svh
`ifndef MOTION_SETTINGS_SVH
`define MOTION_SETTINGS_SVH

// host bus
`define MOTION_DATA_W           32
`define MOTION_ADDR_W           16

// gpio and motor sizing
`define MOTION_GPIO_W           32
`define MOTION_MOTOR_COUNT      2
`define MOTION_PERIOD_W         16
`define MOTION_STEP_W           16

// block codes matched against bus_addr[15:8]
`define MOTION_BLK_GPIO_OUT     8'h00
`define MOTION_BLK_GPIO_IN      8'h01
`define MOTION_BLK_MOTOR_BASE   8'h10   // motor m sits at base + m

`endif
